// ==== rtl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int PC_W       = 32;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4,
    OP_XOR  = 3'd5,
    OP_ADDI = 3'd6,
    OP_LOAD = 3'd7
  } opcode_t;

  typedef enum logic [1:0] {
    ST_EMPTY  = 2'd0, // Nothing held
    ST_PAIR   = 2'd1, // Slot 0 still held
    ST_SECOND = 2'd2  // Only slot 1 left
  } issue_state_t;

  typedef struct packed {
    logic                  valid;
    opcode_t               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [PC_W-1:0]       pc;
  } slot_t;

  // Every real opcode reads rs1 and writes rd
  function automatic logic is_real_op(opcode_t op);
    return op != OP_NOP;
  endfunction

  function automatic logic uses_rs2(opcode_t op);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: return 1'b1;
      default:                               return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== rtl/register_read_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface register_read_if;
  import issue_pkg::*;

  logic [REG_ADDR_W-1:0] raddr1;
  logic [REG_ADDR_W-1:0] raddr2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;

  modport reader (
    output raddr1,
    output raddr2,
    input  rdata1,
    input  rdata2
  );

  modport file (
    input  raddr1,
    input  raddr2,
    output rdata1,
    output rdata2
  );

endinterface

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                             clock,
  input  logic                             reset,
  register_read_if.file                    rd0_if,
  register_read_if.file                    rd1_if,
  input  logic                             wb_valid,
  input  logic [issue_pkg::REG_ADDR_W-1:0] wb_addr,
  input  logic [issue_pkg::XLEN-1:0]       wb_data
);
  import issue_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  function automatic logic [XLEN-1:0] read_reg(logic [REG_ADDR_W-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    return regs[addr];
  endfunction

  // Four combinational read ports
  assign rd0_if.rdata1 = read_reg(rd0_if.raddr1);
  assign rd0_if.rdata2 = read_reg(rd0_if.raddr2);
  assign rd1_if.rdata1 = read_reg(rd1_if.raddr1);
  assign rd1_if.rdata2 = read_reg(rd1_if.raddr2);

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_addr != '0) begin // x0 stays zero
      regs[wb_addr] <= wb_data;
    end
  end

  a_wb_addr_known: assert property (
    @(posedge clock) disable iff (!reset)
    wb_valid |-> !$isunknown(wb_addr)
  ) else $error("register_file: unknown writeback address");

endmodule

`default_nettype wire

// ==== rtl/scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
  input  logic                             clock,
  input  logic                             reset,
  input  issue_pkg::slot_t                 held0,
  input  issue_pkg::slot_t                 held1,
  input  logic                             slot0_gone,
  input  logic                             fire0,
  input  logic                             fire1,
  input  logic                             wb_valid,
  input  logic [issue_pkg::REG_ADDR_W-1:0] wb_addr,
  output logic                             free0,
  output logic                             free1
);
  import issue_pkg::*;

  logic [NUM_REGS-1:0] pending;
  logic [NUM_REGS-1:0] pending_next;

  // True when no register the slot touches has a write in flight
  function automatic logic slot_clear(slot_t s, logic [NUM_REGS-1:0] busy);
    logic hit;
    hit = 1'b0;
    if (is_real_op(s.op) && (busy[s.rs1] || busy[s.rd])) begin
      hit = 1'b1;
    end
    if (uses_rs2(s.op) && busy[s.rs2]) begin
      hit = 1'b1;
    end
    return !hit;
  endfunction

  assign free0 = held0.valid && !slot0_gone && slot_clear(held0, pending);
  assign free1 = held1.valid && slot_clear(held1, pending);

  always_comb begin
    pending_next = pending;
    if (wb_valid) begin
      pending_next[wb_addr] = 1'b0;
    end
    if (fire0 && is_real_op(held0.op)) begin
      pending_next[held0.rd] = 1'b1;
    end
    if (fire1 && is_real_op(held1.op)) begin
      pending_next[held1.rd] = 1'b1;
    end
    pending_next[0] = 1'b0; // x0 never pending
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

  // Every writeback must match an issued write still in flight
  a_wb_was_pending: assert property (
    @(posedge clock) disable iff (!reset)
    (wb_valid && wb_addr != '0) |-> pending[wb_addr]
  ) else $error("scoreboard: writeback to register with no pending write");

endmodule

`default_nettype wire

// ==== rtl/credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         fire0,
  input  logic                         fire1,
  input  logic [1:0]                   credit_return,
  output logic [$clog2(CREDITS+1)-1:0] credits_free
);
  import issue_pkg::*;

  localparam int CNT_W = $clog2(CREDITS + 1);

  int next_count;

  // Issued slots take entries, returned credits free them
  always_comb begin
    next_count = int'(credits_free) + int'(credit_return) - int'(fire0) - int'(fire1);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      credits_free <= CNT_W'(CREDITS); // Queue starts empty
    end else begin
      credits_free <= CNT_W'(next_count);
    end
  end

  // Control must never overdraw and the execute side must never over-return
  a_credit_range: assert property (
    @(posedge clock) disable iff (!reset)
    (next_count >= 0) && (next_count <= CREDITS)
  ) else $error("credit_counter: credit count out of range");

endmodule

`default_nettype wire

// ==== rtl/issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control #(
  parameter int CREDITS = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          valid0,
  input  logic                          valid1,
  input  logic                          ok0,
  input  logic                          ok1,
  input  logic [$clog2(CREDITS+1)-1:0]  credits_free,
  output logic                          fire0,
  output logic                          fire1,
  output logic                          load_pair,
  output logic                          slot0_gone,
  output issue_pkg::issue_state_t       state
);
  import issue_pkg::*;

  issue_state_t next_state;
  logic         one_credit;
  logic         two_credits;
  logic         hold_done;

  assign one_credit  = int'(credits_free) >= 1;
  assign two_credits = int'(credits_free) >= 2;
  assign slot0_gone  = state == ST_SECOND;

  always_comb begin
    fire0      = 1'b0;
    fire1      = 1'b0;
    hold_done  = 1'b1;
    next_state = state;
    case (state)
      ST_PAIR: begin
        fire0     = valid0 && ok0 && one_credit && !flush;
        fire1     = fire0 && valid1 && ok1 && two_credits; // Second credit needed
        hold_done = !valid0 || (fire0 && (fire1 || !valid1));
      end
      ST_SECOND: begin
        fire1     = valid1 && ok1 && one_credit && !flush;
        hold_done = fire1;
      end
      default: begin
        hold_done = 1'b1;
      end
    endcase

    // A flush cycle also holds off the decoder
    load_pair = hold_done && !flush;

    if (flush) begin
      next_state = ST_EMPTY;
    end else if (load_pair) begin
      next_state = ST_PAIR;
    end else if (fire0) begin
      next_state = ST_SECOND;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= ST_EMPTY;
    end else begin
      state <= next_state;
    end
  end

  // Slot 1 stays held until it fires
  a_second_holds_slot1: assert property (
    @(posedge clock) disable iff (!reset)
    (state == ST_SECOND) |-> valid1
  ) else $error("issue_control: no slot 1 held while only slot 1 is left");

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                             clock,
  input  logic                             reset,
  input  issue_pkg::slot_t                 dec_slot0,
  input  issue_pkg::slot_t                 dec_slot1,
  input  logic                             load_pair,
  input  logic                             fire0,
  input  logic                             fire1,
  input  issue_pkg::issue_state_t          state,
  input  logic                             free0,
  input  logic                             free1,
  register_read_if.reader                  rd0_if,
  register_read_if.reader                  rd1_if,
  output issue_pkg::slot_t                 held0,
  output issue_pkg::slot_t                 held1,
  output logic                             ok0,
  output logic                             ok1,
  output logic                             dec_stall,
  output logic                             iss0_valid,
  output issue_pkg::opcode_t               iss0_op,
  output logic [issue_pkg::REG_ADDR_W-1:0] iss0_rd,
  output logic [issue_pkg::XLEN-1:0]       iss0_a,
  output logic [issue_pkg::XLEN-1:0]       iss0_b,
  output logic [issue_pkg::XLEN-1:0]       iss0_imm,
  output logic [issue_pkg::PC_W-1:0]       iss0_pc,
  output logic                             iss1_valid,
  output issue_pkg::opcode_t               iss1_op,
  output logic [issue_pkg::REG_ADDR_W-1:0] iss1_rd,
  output logic [issue_pkg::XLEN-1:0]       iss1_a,
  output logic [issue_pkg::XLEN-1:0]       iss1_b,
  output logic [issue_pkg::XLEN-1:0]       iss1_imm,
  output logic [issue_pkg::PC_W-1:0]       iss1_pc
);
  import issue_pkg::*;

  logic            pair_conflict;
  logic            both_loads;
  logic [XLEN-1:0] op_a0;
  logic [XLEN-1:0] op_b0;
  logic [XLEN-1:0] op_a1;
  logic [XLEN-1:0] op_b1;

  assign dec_stall = !load_pair;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pair hold register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A lone slot 1 moves down into slot 0
  always_ff @(posedge clock) begin
    if (!reset) begin
      held0.valid <= 1'b0;
      held1.valid <= 1'b0;
    end else if (load_pair) begin
      held0       <= dec_slot0.valid ? dec_slot0 : dec_slot1;
      held1       <= dec_slot1;
      held1.valid <= dec_slot0.valid && dec_slot1.valid;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Intra-pair hazards
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    pair_conflict = 1'b0;
    if (is_real_op(held0.op) && held0.rd != '0) begin
      if (is_real_op(held1.op) && (held1.rs1 == held0.rd || held1.rd == held0.rd)) begin
        pair_conflict = 1'b1; // RAW on rs1 or WAW
      end
      if (uses_rs2(held1.op) && held1.rs2 == held0.rd) begin
        pair_conflict = 1'b1;
      end
    end
  end

  assign both_loads = held0.op == OP_LOAD && held1.op == OP_LOAD;

  assign ok0 = free0;
  assign ok1 = free1 && (state == ST_SECOND || (!pair_conflict && !both_loads));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand read and issue regs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd0_if.raddr1 = held0.rs1;
  assign rd0_if.raddr2 = held0.rs2;
  assign rd1_if.raddr1 = held1.rs1;
  assign rd1_if.raddr2 = held1.rs2;

  assign op_a0 = is_real_op(held0.op) ? rd0_if.rdata1 : '0;
  assign op_b0 = uses_rs2(held0.op) ? rd0_if.rdata2 : '0; // Unused source reads zero
  assign op_a1 = is_real_op(held1.op) ? rd1_if.rdata1 : '0;
  assign op_b1 = uses_rs2(held1.op) ? rd1_if.rdata2 : '0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      iss0_valid <= 1'b0;
      iss1_valid <= 1'b0;
    end else begin
      iss0_valid <= fire0;
      iss1_valid <= fire1;
    end
  end

  always_ff @(posedge clock) begin
    if (fire0) begin
      iss0_op  <= held0.op;
      iss0_rd  <= held0.rd;
      iss0_a   <= op_a0;
      iss0_b   <= op_b0;
      iss0_imm <= held0.imm;
      iss0_pc  <= held0.pc;
    end
    if (fire1) begin
      iss1_op  <= held1.op;
      iss1_rd  <= held1.rd;
      iss1_a   <= op_a1;
      iss1_b   <= op_b1;
      iss1_imm <= held1.imm;
      iss1_pc  <= held1.pc;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
  parameter int CREDITS = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  issue_pkg::slot_t                 dec_slot0,
  input  issue_pkg::slot_t                 dec_slot1,
  output logic                             dec_stall,
  input  logic                             flush,
  input  logic                             wb_valid,
  input  logic [issue_pkg::REG_ADDR_W-1:0] wb_addr,
  input  logic [issue_pkg::XLEN-1:0]       wb_data,
  input  logic [1:0]                       credit_return,
  output logic                             iss0_valid,
  output issue_pkg::opcode_t               iss0_op,
  output logic [issue_pkg::REG_ADDR_W-1:0] iss0_rd,
  output logic [issue_pkg::XLEN-1:0]       iss0_a,
  output logic [issue_pkg::XLEN-1:0]       iss0_b,
  output logic [issue_pkg::XLEN-1:0]       iss0_imm,
  output logic [issue_pkg::PC_W-1:0]       iss0_pc,
  output logic                             iss1_valid,
  output issue_pkg::opcode_t               iss1_op,
  output logic [issue_pkg::REG_ADDR_W-1:0] iss1_rd,
  output logic [issue_pkg::XLEN-1:0]       iss1_a,
  output logic [issue_pkg::XLEN-1:0]       iss1_b,
  output logic [issue_pkg::XLEN-1:0]       iss1_imm,
  output logic [issue_pkg::PC_W-1:0]       iss1_pc
);
  import issue_pkg::*;

  localparam int CNT_W = $clog2(CREDITS + 1);

  slot_t            held0;
  slot_t            held1;
  issue_state_t     state;
  logic             free0;
  logic             free1;
  logic             ok0;
  logic             ok1;
  logic             fire0;
  logic             fire1;
  logic             load_pair;
  logic             slot0_gone;
  logic [CNT_W-1:0] credits_free;

  register_read_if rd0_if ();
  register_read_if rd1_if ();

  register_file u_register_file (
    .clock    (clock),
    .reset    (reset),
    .rd0_if   (rd0_if),
    .rd1_if   (rd1_if),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  scoreboard u_scoreboard (
    .clock      (clock),
    .reset      (reset),
    .held0      (held0),
    .held1      (held1),
    .slot0_gone (slot0_gone),
    .fire0      (fire0),
    .fire1      (fire1),
    .wb_valid   (wb_valid),
    .wb_addr    (wb_addr),
    .free0      (free0),
    .free1      (free1)
  );

  credit_counter #(
    .CREDITS (CREDITS)
  ) u_credit_counter (
    .clock         (clock),
    .reset         (reset),
    .fire0         (fire0),
    .fire1         (fire1),
    .credit_return (credit_return),
    .credits_free  (credits_free)
  );

  issue_control #(
    .CREDITS (CREDITS)
  ) u_issue_control (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .valid0       (held0.valid),
    .valid1       (held1.valid),
    .ok0          (ok0),
    .ok1          (ok1),
    .credits_free (credits_free),
    .fire0        (fire0),
    .fire1        (fire1),
    .load_pair    (load_pair),
    .slot0_gone   (slot0_gone),
    .state        (state)
  );

  issue_stage u_issue_stage (
    .clock      (clock),
    .reset      (reset),
    .dec_slot0  (dec_slot0),
    .dec_slot1  (dec_slot1),
    .load_pair  (load_pair),
    .fire0      (fire0),
    .fire1      (fire1),
    .state      (state),
    .free0      (free0),
    .free1      (free1),
    .rd0_if     (rd0_if),
    .rd1_if     (rd1_if),
    .held0      (held0),
    .held1      (held1),
    .ok0        (ok0),
    .ok1        (ok1),
    .dec_stall  (dec_stall),
    .iss0_valid (iss0_valid),
    .iss0_op    (iss0_op),
    .iss0_rd    (iss0_rd),
    .iss0_a     (iss0_a),
    .iss0_b     (iss0_b),
    .iss0_imm   (iss0_imm),
    .iss0_pc    (iss0_pc),
    .iss1_valid (iss1_valid),
    .iss1_op    (iss1_op),
    .iss1_rd    (iss1_rd),
    .iss1_a     (iss1_a),
    .iss1_b     (iss1_b),
    .iss1_imm   (iss1_imm),
    .iss1_pc    (iss1_pc)
  );

endmodule

`default_nettype wire

// ==== verification/issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_tb;
  import issue_pkg::*;

  localparam int CREDITS     = 4;
  localparam int NUM_DIRECT  = 6;
  localparam int NUM_INSTR   = NUM_DIRECT + 300;
  localparam int IDLE_CYCLES = 4;
  localparam int TIMEOUT     = 40 * NUM_INSTR;

  logic                  clock;
  logic                  reset;
  slot_t                 dec_slot0;
  slot_t                 dec_slot1;
  logic                  dec_stall;
  logic                  flush;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_addr;
  logic [XLEN-1:0]       wb_data;
  logic [1:0]            credit_return;
  logic                  iss0_valid;
  opcode_t               iss0_op;
  logic [REG_ADDR_W-1:0] iss0_rd;
  logic [XLEN-1:0]       iss0_a;
  logic [XLEN-1:0]       iss0_b;
  logic [XLEN-1:0]       iss0_imm;
  logic [PC_W-1:0]       iss0_pc;
  logic                  iss1_valid;
  opcode_t               iss1_op;
  logic [REG_ADDR_W-1:0] iss1_rd;
  logic [XLEN-1:0]       iss1_a;
  logic [XLEN-1:0]       iss1_b;
  logic [XLEN-1:0]       iss1_imm;
  logic [PC_W-1:0]       iss1_pc;

  opcode_t               prog_op     [NUM_INSTR];
  logic [REG_ADDR_W-1:0] prog_rd     [NUM_INSTR];
  logic [REG_ADDR_W-1:0] prog_rs1    [NUM_INSTR];
  logic [REG_ADDR_W-1:0] prog_rs2    [NUM_INSTR];
  logic [XLEN-1:0]       prog_imm    [NUM_INSTR];
  int                    issue_cycle [NUM_INSTR];
  logic [XLEN-1:0]       ref_regs    [NUM_REGS];

  int                    held_q [$]; // Accepted but not yet issued
  logic [REG_ADDR_W-1:0] inflight_rd [$];
  logic [XLEN-1:0]       inflight_data [$];
  int                    inflight_ready [$];

  int   cycle;
  int   dec_idx;
  int   issued_count;
  int   dropped_count;
  int   hold_cycles;
  logic hold_started;
  logic dropped_any;
  logic done;

  issue_top #(
    .CREDITS (CREDITS)
  ) UUT (.*);

  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_values(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic set_instr(input int idx, input opcode_t op, input logic [REG_ADDR_W-1:0] rd,
                           input logic [REG_ADDR_W-1:0] rs1, input logic [REG_ADDR_W-1:0] rs2,
                           input logic [XLEN-1:0] imm);
    prog_op[idx]  = op;
    prog_rd[idx]  = rd;
    prog_rs1[idx] = rs1;
    prog_rs2[idx] = rs2;
    prog_imm[idx] = imm;
  endtask

  function automatic slot_t make_slot(input int idx);
    slot_t s;
    s = '0;
    if (idx < NUM_INSTR) begin
      s.valid = 1'b1;
      s.op    = prog_op[idx];
      s.rd    = prog_rd[idx];
      s.rs1   = prog_rs1[idx];
      s.rs2   = prog_rs2[idx];
      s.imm   = prog_imm[idx];
      s.pc    = PC_W'(idx * 4);
    end
    return s;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Runs one instruction on the in-order register state
  function automatic logic [XLEN-1:0] reference_exec(input int idx,
                                                     output logic [XLEN-1:0] exp_a,
                                                     output logic [XLEN-1:0] exp_b);
    logic [XLEN-1:0] result;
    exp_a = ref_regs[prog_rs1[idx]];
    case (prog_op[idx])
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: exp_b = ref_regs[prog_rs2[idx]];
      default:                               exp_b = '0;
    endcase
    case (prog_op[idx])
      OP_ADD:  result = exp_a + exp_b;
      OP_SUB:  result = exp_a - exp_b;
      OP_AND:  result = exp_a & exp_b;
      OP_OR:   result = exp_a | exp_b;
      OP_XOR:  result = exp_a ^ exp_b;
      OP_ADDI: result = exp_a + prog_imm[idx];
      OP_LOAD: result = ~(exp_a + prog_imm[idx]); // Stand-in for memory data
      default: result = '0;
    endcase
    if (prog_rd[idx] != '0) begin
      ref_regs[prog_rd[idx]] = result;
    end
    return result;
  endfunction

  task automatic check_slot(input opcode_t op, input logic [REG_ADDR_W-1:0] rd,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic [XLEN-1:0] imm, input logic [PC_W-1:0] pc);
    int              idx;
    string           tag;
    logic [XLEN-1:0] exp_a;
    logic [XLEN-1:0] exp_b;
    logic [XLEN-1:0] result;
    if (held_q.size() == 0) begin
      fail_run($sformatf("An instruction issued with pc %h while nothing was held", pc));
    end
    idx = held_q.pop_front(); // Oldest held is next in program order
    tag = $sformatf("instr %0d", idx);
    compare_values({tag, " pc"}, PC_W'(idx * 4), pc);
    result = reference_exec(idx, exp_a, exp_b);
    compare_values({tag, " op"}, XLEN'(prog_op[idx]), XLEN'(op));
    compare_values({tag, " rd"}, XLEN'(prog_rd[idx]), XLEN'(rd));
    compare_values({tag, " a"}, exp_a, a);
    compare_values({tag, " b"}, exp_b, b);
    compare_values({tag, " imm"}, prog_imm[idx], imm);
    issue_cycle[idx] = cycle;
    issued_count++;
    inflight_rd.push_back(rd);
    inflight_data.push_back(result);
    inflight_ready.push_back(cycle + 1 + int'($urandom % 6));
    compare_values({tag, " outstanding within credits"}, XLEN'(1),
                   XLEN'(inflight_rd.size() <= CREDITS));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checker
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin : monitor
    int k;
    if (cycle > TIMEOUT) begin
      fail_run($sformatf("Timeout after %0d cycles, %0d issued and %0d dropped of %0d",
                         cycle, issued_count, dropped_count, NUM_INSTR));
    end
    if (reset) begin
      if (cycle < IDLE_CYCLES) begin
        compare_values("idle iss0_valid", '0, XLEN'(iss0_valid));
        compare_values("idle iss1_valid", '0, XLEN'(iss1_valid));
        compare_values("idle dec_stall", '0, XLEN'(dec_stall));
      end
      if (iss0_valid) check_slot(iss0_op, iss0_rd, iss0_a, iss0_b, iss0_imm, iss0_pc);
      if (iss1_valid) check_slot(iss1_op, iss1_rd, iss1_a, iss1_b, iss1_imm, iss1_pc);
      if (flush) begin // Whatever is still held never issues
        while (held_q.size() > 0) begin
          k = held_q.pop_front();
          dropped_count++;
          dropped_any = 1'b1;
        end
      end
      if (!dec_stall && dec_slot0.valid) begin
        held_q.push_back(dec_idx);
        dec_idx++;
        if (dec_slot1.valid) begin
          held_q.push_back(dec_idx);
          dec_idx++;
        end
      end
      if (!hold_started && issued_count >= 100) begin
        hold_started = 1'b1;
        hold_cycles  = 40; // Execute side sits on its credits
      end
      if (issued_count + dropped_count == NUM_INSTR && inflight_rd.size() == 0) begin
        done = 1'b1;
      end
      cycle++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decoder and execute model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clock) begin : drive
    int pick;
    pick          = -1;
    wb_valid      = 1'b0;
    wb_addr       = '0;
    wb_data       = '0;
    credit_return = 2'd0;
    flush         = 1'b0;
    if (cycle >= IDLE_CYCLES) begin
      dec_slot0 = make_slot(dec_idx);
      dec_slot1 = make_slot(dec_idx + 1);
    end
    if (hold_cycles > 0) begin
      hold_cycles--;
    end else begin
      for (int i = 0; i < inflight_rd.size(); i++) begin
        if (pick < 0 && inflight_ready[i] <= cycle) pick = i;
      end
      if (pick >= 0) begin // One writeback per cycle frees its entry
        wb_valid      = 1'b1;
        wb_addr       = inflight_rd[pick];
        wb_data       = inflight_data[pick];
        credit_return = 2'd1;
        inflight_rd.delete(pick);
        inflight_data.delete(pick);
        inflight_ready.delete(pick);
      end
    end
    if (held_q.size() > 0 && held_q[0] >= NUM_DIRECT) begin
      if (($urandom % 64) == 0 || (!dropped_any && held_q[0] >= 150)) flush = 1'b1;
    end
  end

  initial begin
    clock         = 1'b0;
    reset         = 1'b0;
    dec_slot0     = '0;
    dec_slot1     = '0;
    flush         = 1'b0;
    wb_valid      = 1'b0;
    wb_addr       = '0;
    wb_data       = '0;
    credit_return = 2'd0;
    cycle         = 0;
    dec_idx       = 0;
    issued_count  = 0;
    dropped_count = 0;
    hold_cycles   = 0;
    hold_started  = 1'b0;
    dropped_any   = 1'b0;
    done          = 1'b0;
    void'($urandom(32'ha945));
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < NUM_INSTR; i++) begin
      issue_cycle[i] = -1;
    end

    set_instr(0, OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5); // Independent pair
    set_instr(1, OP_ADDI, 5'd2, 5'd3, 5'd0, 32'd7);
    set_instr(2, OP_ADD, 5'd3, 5'd1, 5'd2, 32'd0);  // Slot 1 reads slot 0's rd
    set_instr(3, OP_SUB, 5'd4, 5'd3, 5'd1, 32'd0);
    set_instr(4, OP_LOAD, 5'd5, 5'd1, 5'd0, 32'd16);
    set_instr(5, OP_LOAD, 5'd6, 5'd2, 5'd0, 32'd32);
    for (int i = NUM_DIRECT; i < NUM_INSTR; i++) begin
      prog_op[i]  = opcode_t'(3'(1 + ($urandom % 7)));
      prog_rd[i]  = REG_ADDR_W'($urandom % 8); // Few registers give many hazards
      prog_rs1[i] = REG_ADDR_W'($urandom % 8);
      prog_rs2[i] = REG_ADDR_W'($urandom % 8);
      prog_imm[i] = $urandom;
    end

    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    wait (done);

    compare_values("independent pair issue cycle", XLEN'(issue_cycle[0]),
                   XLEN'(issue_cycle[1]));
    compare_values("dependent pair slot 1 later", XLEN'(1),
                   XLEN'(issue_cycle[3] > issue_cycle[2]));
    compare_values("load pair slot 1 later", XLEN'(1), XLEN'(issue_cycle[5] > issue_cycle[4]));
    compare_values("flush dropped a held pair", XLEN'(1), XLEN'(dropped_any));
    compare_values("credit hold window ran", XLEN'(1), XLEN'(hold_started));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/issue_pkg.sv
rtl/register_read_if.sv
rtl/register_file.sv
rtl/scoreboard.sv
rtl/credit_counter.sv
rtl/issue_control.sv
rtl/issue_stage.sv
rtl/issue_top.sv
verification/issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
